// File: verilog/amm_tg_settings.svh
////////////////////////////////////////////////////////////////////////////
// Memory traffic generator settings
// Bus widths, the read watchdog limit and command bridge sizing
////////////////////////////////////////////////////////////////////////////

`ifndef AMM_TG_SETTINGS_SVH
`define AMM_TG_SETTINGS_SVH

// Word address width of the memory port
`define AMM_TG_ADDR_WIDTH       16
// Data width of one memory word, a whole number of 16-bit lanes
`define AMM_TG_DATA_WIDTH       64
// Width of the configured word count
`define AMM_TG_COUNT_WIDTH      16

// Cycles without a returned read word before the test gives up
`define AMM_TG_WATCHDOG_CYCLES  256
// Timer must be able to hold the limit itself
`define AMM_TG_WATCHDOG_WIDTH   9

// Command FIFO depth and its pointer width including the wrap bit
`define AMM_TG_BRIDGE_DEPTH     2
`define AMM_TG_BRIDGE_PTR_WIDTH 2

`endif

// File: verilog/amm_tg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Memory traffic generator types
// Command, configuration and status structs, FSM states, data pattern
////////////////////////////////////////////////////////////////////////////

`include "amm_tg_settings.svh"

package amm_tg_pkg;

   // Number of 16-bit lanes in one data word
   localparam int PATTERN_LANES = `AMM_TG_DATA_WIDTH / 16;

   // One single-beat Avalon-MM command
   typedef struct packed {
      logic                          write;
      logic                          read;
      logic [`AMM_TG_ADDR_WIDTH-1:0] address;
      logic [`AMM_TG_DATA_WIDTH-1:0] writedata;
   } amm_cmd_t;

   // Test setup, held stable by the user for the whole run
   typedef struct packed {
      logic [`AMM_TG_ADDR_WIDTH-1:0]  base_address;
      logic [`AMM_TG_COUNT_WIDTH-1:0] num_words;
      logic [7:0]                     pattern_seed;
   } tg_config_t;

   // Result of the last run; done is a single-cycle strobe
   typedef struct packed {
      logic                          busy;
      logic                          done;
      logic                          pass;
      logic                          timeout;
      logic [15:0]                   fail_count;
      logic [`AMM_TG_ADDR_WIDTH-1:0] first_fail_address;
   } tg_status_t;

   typedef enum logic [2:0] {IDLE, WRITE, READ, WAIT_READS, FINISH} tg_state_t;

   // Each lane is the address XOR lane index times 0x1111 XOR the doubled seed
   function automatic logic [`AMM_TG_DATA_WIDTH-1:0] tg_pattern(
      input logic [`AMM_TG_ADDR_WIDTH-1:0] address,
      input logic [7:0]                    seed
   );
      logic [`AMM_TG_DATA_WIDTH-1:0] word;
      word = '0;
      for (int lane = 0; lane < PATTERN_LANES; lane++) begin
         word[16*lane +: 16] = 16'(address) ^ (16'(lane) * 16'h1111) ^ {seed, seed};
      end
      return word;
   endfunction

endpackage

// File: verilog/amm_tg_cmd_bridge.sv
////////////////////////////////////////////////////////////////////////////
// Command bridge between the generator and the memory port
// Two-entry FIFO feeding a register stage, no ready path through it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "amm_tg_settings.svh"

module amm_tg_cmd_bridge (
   input  logic                clk,
   input  logic                reset_n,
   input  amm_tg_pkg::amm_cmd_t gen_cmd,
   output logic                gen_ready,
   output amm_tg_pkg::amm_cmd_t mem_cmd,
   input  logic                mem_ready
);
   import amm_tg_pkg::*;

   localparam int DEPTH = `AMM_TG_BRIDGE_DEPTH;
   localparam int PTR_W = `AMM_TG_BRIDGE_PTR_WIDTH;

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             fifo_empty;
   logic             fifo_full;
   logic             out_of_reset;
   logic             accept_cmd;
   logic             load_output;

   amm_cmd_t         fifo_mem [0:DEPTH-1];
   amm_cmd_t         fifo_head;
   amm_cmd_t         out_payload;
   logic             out_write;
   logic             out_read;

   // Equal pointers mean empty; only the wrap bit differing means full
   assign fifo_empty = (wr_ptr == rd_ptr);
   assign fifo_full  = (wr_ptr[PTR_W-1] != rd_ptr[PTR_W-1]) &&
                       (wr_ptr[PTR_W-2:0] == rd_ptr[PTR_W-2:0]);
   assign fifo_head  = fifo_mem[rd_ptr[PTR_W-2:0]];

   // Registered flag keeps gen_ready low in the first cycle after reset
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         out_of_reset <= 1'b0;
      end else begin
         out_of_reset <= 1'b1;
      end
   end

   // Ready depends on FIFO state only, never on mem_ready
   assign gen_ready  = !fifo_full && out_of_reset;
   assign accept_cmd = (gen_cmd.write || gen_cmd.read) && gen_ready;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         wr_ptr <= '0;
      end else if (accept_cmd) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // The free slot may be overwritten each cycle, it only counts once wr_ptr moves
   always_ff @(posedge clk) begin
      if (!fifo_full) begin
         fifo_mem[wr_ptr[PTR_W-2:0]] <= gen_cmd;
      end
   end

   // Register stage takes a new command when idle or when the memory accepts
   assign load_output = mem_ready || !(out_write || out_read);

   // Stale FIFO contents must never reach the port, so an empty FIFO loads idle
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         out_write <= 1'b0;
         out_read  <= 1'b0;
      end else if (load_output) begin
         out_write <= !fifo_empty && fifo_head.write;
         out_read  <= !fifo_empty && fifo_head.read;
      end
   end

   // Address and data only need to hold while the port is stalled
   always_ff @(posedge clk) begin
      if (load_output) begin
         out_payload <= fifo_head;
      end
   end

   // Head leaves the FIFO as it moves into the register stage
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         rd_ptr <= '0;
      end else if (load_output && !fifo_empty) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   assign mem_cmd = '{write:     out_write,
                      read:      out_read,
                      address:   out_payload.address,
                      writedata: out_payload.writedata};

endmodule

// File: verilog/amm_tg_counters.sv
////////////////////////////////////////////////////////////////////////////
// Word address counter and read watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "amm_tg_settings.svh"

module amm_tg_counters (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           cnt_load,
   input  logic                           cmd_accepted,
   input  logic [`AMM_TG_ADDR_WIDTH-1:0]  base_address,
   input  logic [`AMM_TG_COUNT_WIDTH-1:0] num_words,
   input  logic                           mem_readdatavalid,
   input  logic                           watchdog_run,
   output logic [`AMM_TG_ADDR_WIDTH-1:0]  word_address,
   output logic                           last_word,
   output logic                           watchdog_expired
);

   logic [`AMM_TG_COUNT_WIDTH-1:0]    words_left;
   logic [`AMM_TG_WATCHDOG_WIDTH-1:0] watchdog_timer;

   ///////////////////////////////////////////////////////////////////////////
   // Address and remaining words
   ///////////////////////////////////////////////////////////////////////////

   // A load wins over a step, so the phase switch can reload on the last accept
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         word_address <= '0;
         words_left   <= '0;
      end else if (cnt_load) begin
         word_address <= base_address;
         words_left   <= num_words;
      end else if (cmd_accepted) begin
         word_address <= word_address + 1'b1;
         words_left   <= words_left - 1'b1;
      end
   end

   // A zero count also ends the phase after one command instead of wrapping
   assign last_word = (words_left < 2);

   ///////////////////////////////////////////////////////////////////////////
   // Read watchdog
   ///////////////////////////////////////////////////////////////////////////

   // Every returned word restarts the count; outside the wait phase it idles at zero
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         watchdog_timer <= '0;
      end else if (!watchdog_run || mem_readdatavalid) begin
         watchdog_timer <= '0;
      end else if (!watchdog_expired) begin
         watchdog_timer <= watchdog_timer + 1'b1;
      end
   end

   // Timer stops at the limit
   assign watchdog_expired = (watchdog_timer == `AMM_TG_WATCHDOG_CYCLES);

endmodule

// File: verilog/amm_tg_ctrl_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Test sequencer
// Writes the block, reads it back, waits for data and reports completion
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "amm_tg_settings.svh"

module amm_tg_ctrl_fsm (
   input  logic                          clk,
   input  logic                          reset_n,
   input  logic                          start,
   input  amm_tg_pkg::tg_config_t        cfg,
   input  logic                          gen_ready,
   input  logic [`AMM_TG_ADDR_WIDTH-1:0] word_address,
   input  logic                          last_word,
   input  logic                          all_reads_back,
   input  logic                          watchdog_expired,
   output logic                          cnt_load,
   output logic                          cmd_accepted,
   output logic                          watchdog_run,
   output amm_tg_pkg::amm_cmd_t          gen_cmd,
   output logic                          busy,
   output logic                          done,
   output logic                          timeout,
   output logic                          check_clear
);
   import amm_tg_pkg::*;

   tg_state_t state;
   tg_state_t next_state;

   // Payload is always formed, the phase decides which strobe goes with it
   assign gen_cmd = '{write:     (state == WRITE),
                      read:      (state == READ),
                      address:   word_address,
                      writedata: tg_pattern(word_address, cfg.pattern_seed)};

   // Counters and FSM move together on the accepting edge
   assign cmd_accepted = (gen_cmd.write || gen_cmd.read) && gen_ready;

   always_comb begin
      next_state  = state;
      cnt_load    = 1'b0;
      check_clear = 1'b0;
      case (state)
         IDLE: begin
            // Start arms the counters and clears the checker
            if (start) begin
               cnt_load    = 1'b1;
               check_clear = 1'b1;
               next_state  = WRITE;
            end
         end
         WRITE: begin
            // Reload the counter from the base for the read pass
            if (cmd_accepted && last_word) begin
               cnt_load   = 1'b1;
               next_state = READ;
            end
         end
         READ: begin
            if (cmd_accepted && last_word) begin
               next_state = WAIT_READS;
            end
         end
         WAIT_READS: begin
            if (all_reads_back || watchdog_expired) begin
               next_state = FINISH;
            end
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   // Timeout only counts if the data did not make it back first
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         timeout <= 1'b0;
      end else if (check_clear) begin
         timeout <= 1'b0;
      end else if (state == WAIT_READS && !all_reads_back && watchdog_expired) begin
         timeout <= 1'b1;
      end
   end

   // FINISH lasts exactly one cycle, which makes done a clean pulse
   assign done         = (state == FINISH);
   assign busy         = (state != IDLE);
   assign watchdog_run = (state == WAIT_READS);

endmodule

// File: verilog/amm_tg_read_checker.sv
////////////////////////////////////////////////////////////////////////////
// Read data checker
// Compares returned words with the pattern and logs mismatches
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "amm_tg_settings.svh"

module amm_tg_read_checker (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           check_clear,
   input  logic [`AMM_TG_ADDR_WIDTH-1:0]  base_address,
   input  logic [`AMM_TG_COUNT_WIDTH-1:0] num_words,
   input  logic [7:0]                     pattern_seed,
   input  logic [`AMM_TG_DATA_WIDTH-1:0]  mem_readdata,
   input  logic                           mem_readdatavalid,
   output logic                           all_reads_back,
   output logic [15:0]                    fail_count,
   output logic [`AMM_TG_ADDR_WIDTH-1:0]  first_fail_address,
   output logic                           mismatch_seen
);
   import amm_tg_pkg::*;

   localparam int ADDR_W = `AMM_TG_ADDR_WIDTH;

   logic [`AMM_TG_COUNT_WIDTH-1:0] recv_count;
   logic [ADDR_W-1:0]              expected_address;
   logic                           armed;
   logic                           word_bad;

   // Reads return in order, so the word index gives the address
   assign expected_address = base_address + ADDR_W'(recv_count);

   // Compare in the arrival cycle, record on the next edge
   assign word_bad = mem_readdatavalid &&
                     (mem_readdata != tg_pattern(expected_address, pattern_seed));

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         recv_count <= '0;
         armed      <= 1'b0;
      end else if (check_clear) begin
         recv_count <= '0;
         armed      <= 1'b1;
      end else if (mem_readdatavalid) begin
         recv_count <= recv_count + 1'b1;
      end
   end

   // Armed keeps a zero count right after reset from looking like a finished run
   assign all_reads_back = armed && (recv_count == num_words);

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         fail_count         <= '0;
         first_fail_address <= '0;
         mismatch_seen      <= 1'b0;
      end else if (check_clear) begin
         fail_count         <= '0;
         first_fail_address <= '0;
         mismatch_seen      <= 1'b0;
      end else if (word_bad) begin
         // Count stops at all ones
         if (fail_count != '1) begin
            fail_count <= fail_count + 1'b1;
         end
         // Only the first bad address is kept
         if (!mismatch_seen) begin
            first_fail_address <= expected_address;
         end
         mismatch_seen <= 1'b1;
      end
   end

endmodule

// File: verilog/amm_tg_top.sv
////////////////////////////////////////////////////////////////////////////
// Memory traffic generator top level
// Sequencer, counters, command bridge and checker on one Avalon-MM port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "amm_tg_settings.svh"

module amm_tg_top (
   input  logic                          clk,
   input  logic                          reset_n,
   input  logic                          start,
   input  amm_tg_pkg::tg_config_t        cfg,
   output amm_tg_pkg::tg_status_t        status,
   output amm_tg_pkg::amm_cmd_t          mem_cmd,
   input  logic                          mem_ready,
   input  logic [`AMM_TG_DATA_WIDTH-1:0] mem_readdata,
   input  logic                          mem_readdatavalid
);
   import amm_tg_pkg::*;

   amm_cmd_t                      gen_cmd;
   logic                          gen_ready;
   logic                          cnt_load;
   logic                          cmd_accepted;
   logic                          watchdog_run;
   logic                          watchdog_expired;
   logic [`AMM_TG_ADDR_WIDTH-1:0] word_address;
   logic                          last_word;
   logic                          all_reads_back;
   logic                          check_clear;
   logic                          busy;
   logic                          done;
   logic                          timeout;
   logic                          mismatch_seen;
   logic [15:0]                   fail_count;
   logic [`AMM_TG_ADDR_WIDTH-1:0] first_fail_address;

   amm_tg_ctrl_fsm amm_tg_ctrl_fsm_i (
      .clk, .reset_n, .start, .cfg, .gen_ready, .word_address, .last_word,
      .all_reads_back, .watchdog_expired, .cnt_load, .cmd_accepted,
      .watchdog_run, .gen_cmd, .busy, .done, .timeout, .check_clear
   );

   amm_tg_counters amm_tg_counters_i (
      .clk, .reset_n, .cnt_load, .cmd_accepted,
      .base_address (cfg.base_address),
      .num_words    (cfg.num_words),
      .mem_readdatavalid, .watchdog_run, .word_address, .last_word, .watchdog_expired
   );

   amm_tg_cmd_bridge amm_tg_cmd_bridge_i (
      .clk, .reset_n, .gen_cmd, .gen_ready, .mem_cmd, .mem_ready
   );

   amm_tg_read_checker amm_tg_read_checker_i (
      .clk, .reset_n, .check_clear,
      .base_address (cfg.base_address),
      .num_words    (cfg.num_words),
      .pattern_seed (cfg.pattern_seed),
      .mem_readdata, .mem_readdatavalid, .all_reads_back,
      .fail_count, .first_fail_address, .mismatch_seen
   );

   // Pass needs a finished read-back with no bad word and no timeout
   assign status = '{busy:               busy,
                     done:               done,
                     pass:               all_reads_back && !mismatch_seen && !timeout,
                     timeout:            timeout,
                     fail_count:         fail_count,
                     first_fail_address: first_fail_address};

endmodule

// File: tests/amm_tg_tb.sv
////////////////////////////////////////////////////////////////////////////
// Memory traffic generator testbench
// Directed tests against a behavioral Avalon-MM memory with random stalls
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "amm_tg_settings.svh"

module amm_tg_tb;
   import amm_tg_pkg::*;

   localparam int ADDR_W     = `AMM_TG_ADDR_WIDTH;
   localparam int DATA_W     = `AMM_TG_DATA_WIDTH;
   localparam int DONE_LIMIT = 5000;

   // One pending read response inside the memory model
   typedef struct packed {
      logic [31:0]       due;
      logic [ADDR_W-1:0] address;
      logic [DATA_W-1:0] data;
   } read_rsp_t;

   logic              clk = 1'b0;
   logic              reset_n;
   logic              start;
   tg_config_t        cfg;
   tg_status_t        status;
   amm_cmd_t          mem_cmd;
   logic              mem_ready = 1'b0;
   logic [DATA_W-1:0] mem_readdata = '0;
   logic              mem_readdatavalid = 1'b0;

   // Memory model controls, changed only between runs
   logic              ready_random = 1'b0;
   logic              drop_reads = 1'b0;
   logic              corrupt_on = 1'b0;
   logic [ADDR_W-1:0] corrupt_address = '0;

   logic [DATA_W-1:0] mem_words [logic [ADDR_W-1:0]];
   read_rsp_t         rsp_queue [$];
   logic [15:0]       lfsr_state = 16'd63;
   logic [31:0]       cycle_count = '0;

   // Command monitor state
   logic [ADDR_W-1:0] mon_base = '0;
   logic [7:0]        mon_seed = '0;
   logic [15:0]       mon_words = '0;
   logic [15:0]       writes_seen = '0;
   logic [15:0]       reads_seen = '0;
   logic              mon_stalled = 1'b0;
   amm_cmd_t          mon_held;
   int                stall_cycles = 0;

   string             current_test = "setup";
   int                error_count = 0;
   int                errors_at_start = 0;
   int                tests_run = 0;
   int                tests_failed = 0;
   tg_status_t        last_status;

   amm_tg_top amm_tg_top_i (
      .clk, .reset_n, .start, .cfg, .status, .mem_cmd,
      .mem_ready, .mem_readdata, .mem_readdatavalid
   );

   always #5 clk = ~clk;

   ///////////////////////////////////////////////////////////////////////////
   // Random bits and reference data
   ///////////////////////////////////////////////////////////////////////////

   // Fibonacci LFSR for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // Every bit used by the model costs one LFSR step
   task automatic take_bit(output logic b);
      b = lfsr_state[15];
      lfsr_state = lfsr_next(lfsr_state);
   endtask

   // Lane n holds the address XOR n repeated in every nibble XOR the seed twice
   function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] address,
                                                       input logic [7:0] seed);
      logic [DATA_W-1:0] word;
      logic [3:0]        lane_nibble;
      word = '0;
      for (int lane = 0; lane < DATA_W / 16; lane++) begin
         lane_nibble = 4'(lane);
         word[16*lane +: 16] = 16'(address) ^ {4{lane_nibble}} ^ {seed, seed};
      end
      return word;
   endfunction

   // Unwritten locations read back as a mix of the full address
   function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] address);
      return {(DATA_W / 16){16'(address) ^ 16'ha5c3}};
   endfunction

   ///////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ///////////////////////////////////////////////////////////////////////////

   task automatic check_flag(input string field, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("ERR %s %s: expected %0b, actual %0b", current_test, field, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_count(input string field, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (actual !== expected) begin
         $display("ERR %s %s: expected %0d, actual %0d", current_test, field, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_address(input string field, input logic [ADDR_W-1:0] expected,
                                input logic [ADDR_W-1:0] actual);
      if (actual !== expected) begin
         $display("ERR %s %s: expected %h, actual %h", current_test, field, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_command(input string field, input amm_cmd_t expected,
                                input amm_cmd_t actual);
      if (actual !== expected) begin
         $display("ERR %s %s: expected %h, actual %h", current_test, field, expected, actual);
         error_count++;
      end
   endtask

   task automatic report_problem(input string text);
      $display("%s: %s", current_test, text);
      error_count++;
   endtask

   ///////////////////////////////////////////////////////////////////////////
   // Behavioral memory slave
   ///////////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin : memory_model
      logic      b0;
      logic      b1;
      read_rsp_t rsp;
      cycle_count = cycle_count + 32'd1;
      // Responses leave in order, at most one per cycle
      if (rsp_queue.size() > 0 && rsp_queue[0].due <= cycle_count) begin
         rsp = rsp_queue.pop_front();
         if (corrupt_on && rsp.address == corrupt_address) begin
            mem_readdata <= rsp.data ^ 64'h20;
         end else begin
            mem_readdata <= rsp.data;
         end
         mem_readdatavalid <= 1'b1;
      end else begin
         mem_readdatavalid <= 1'b0;
      end
      if (reset_n && mem_ready && mem_cmd.write) begin
         mem_words[mem_cmd.address] = mem_cmd.writedata;
      end
      // Read latency is one to four cycles
      if (reset_n && mem_ready && mem_cmd.read && !drop_reads) begin
         take_bit(b0);
         take_bit(b1);
         rsp.due     = cycle_count + 32'd1 + 32'({b1, b0});
         rsp.address = mem_cmd.address;
         if (mem_words.exists(mem_cmd.address)) begin
            rsp.data = mem_words[mem_cmd.address];
         end else begin
            rsp.data = fill_word(mem_cmd.address);
         end
         rsp_queue.push_back(rsp);
      end
      // Random mode stalls about one cycle in four
      if (ready_random) begin
         take_bit(b0);
         take_bit(b1);
         mem_ready <= b0 | b1;
      end else begin
         mem_ready <= 1'b1;
      end
   end

   ///////////////////////////////////////////////////////////////////////////
   // Command monitor
   ///////////////////////////////////////////////////////////////////////////

   task automatic check_write;
      amm_cmd_t expected;
      if (reads_seen != 0 || writes_seen >= mon_words) begin
         report_problem("write command outside the write phase");
      end else begin
         expected = '{write: 1'b1, read: 1'b0, address: mon_base + writes_seen,
                      writedata: expected_word(mon_base + writes_seen, mon_seed)};
         check_command("write command", expected, mem_cmd);
      end
      writes_seen = writes_seen + 16'd1;
   endtask

   // Write data is meaningless on a read, so it is masked on both sides
   task automatic check_read;
      amm_cmd_t expected;
      amm_cmd_t actual;
      if (writes_seen != mon_words || reads_seen >= mon_words) begin
         report_problem("read command before the writes finished or past the block");
      end else begin
         expected = '{write: 1'b0, read: 1'b1, address: mon_base + reads_seen, writedata: '0};
         actual = mem_cmd;
         actual.writedata = '0;
         check_command("read command", expected, actual);
      end
      reads_seen = reads_seen + 16'd1;
   endtask

   always @(posedge clk) begin
      if (reset_n) begin
         // The monitor takes the block setup from the start the DUT accepts
         if (start && !status.busy) begin
            mon_base    = cfg.base_address;
            mon_seed    = cfg.pattern_seed;
            mon_words   = cfg.num_words;
            writes_seen = '0;
            reads_seen  = '0;
         end
         if (mon_stalled) begin
            check_command("stalled command", mon_held, mem_cmd);
         end
         if (mem_cmd.write && mem_ready) begin
            check_write();
         end
         if (mem_cmd.read && mem_ready) begin
            check_read();
         end
         mon_stalled = (mem_cmd.write || mem_cmd.read) && !mem_ready;
         mon_held    = mem_cmd;
         if (mon_stalled) begin
            stall_cycles++;
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////////
   // Run control
   ///////////////////////////////////////////////////////////////////////////

   task automatic begin_test(input string name);
      current_test    = name;
      errors_at_start = error_count;
   endtask

   task automatic end_test;
      int errors;
      errors = error_count - errors_at_start;
      tests_run++;
      if (errors == 0) begin
         $display("test %s: passed", current_test);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", current_test, errors);
      end
   endtask

   function automatic tg_config_t make_config(input logic [ADDR_W-1:0] base,
                                              input logic [15:0] words,
                                              input logic [7:0] seed);
      return '{base_address: base, num_words: words, pattern_seed: seed};
   endfunction

   // Start is only sent once the previous run has left busy
   task automatic start_run(input tg_config_t c);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (status.busy && cycles < DONE_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (status.busy) begin
         report_problem("generator still busy before start");
      end
      @(posedge clk);
      cfg   <= c;
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
   endtask

   // Status is captured in the middle of the done cycle
   task automatic wait_done;
      int cycles;
      bit seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < DONE_LIMIT) begin
         @(negedge clk);
         cycles++;
         if (status.done) begin
            seen        = 1'b1;
            last_status = status;
         end
      end
      if (!seen) begin
         report_problem($sformatf("no done pulse within %0d cycles", DONE_LIMIT));
         last_status = status;
      end
   endtask

   task automatic check_clean_run(input tg_config_t c);
      check_flag("pass", 1'b1, last_status.pass);
      check_flag("timeout", 1'b0, last_status.timeout);
      check_count("fail_count", 16'd0, last_status.fail_count);
      check_count("writes seen", c.num_words, writes_seen);
      check_count("reads seen", c.num_words, reads_seen);
   endtask

   ///////////////////////////////////////////////////////////////////////////
   // Tests
   ///////////////////////////////////////////////////////////////////////////

   task automatic test_reset_state;
      begin_test("reset_state");
      @(negedge clk);
      check_flag("mem_cmd.write", 1'b0, mem_cmd.write);
      check_flag("mem_cmd.read", 1'b0, mem_cmd.read);
      check_flag("busy", 1'b0, status.busy);
      check_flag("done", 1'b0, status.done);
      check_flag("timeout", 1'b0, status.timeout);
      check_flag("pass", 1'b0, status.pass);
      check_count("fail_count", 16'd0, status.fail_count);
      end_test();
   endtask

   task automatic test_basic_pass;
      tg_config_t c;
      begin_test("basic_pass");
      ready_random = 1'b0;
      c = make_config(16'h0100, 16'd32, 8'h5a);
      start_run(c);
      wait_done();
      check_clean_run(c);
      end_test();
   endtask

   task automatic test_back_pressure;
      tg_config_t c;
      int         stalls_before;
      begin_test("back_pressure");
      ready_random  = 1'b1;
      stalls_before = stall_cycles;
      c = make_config(16'h1000, 16'd32, 8'hc3);
      start_run(c);
      wait_done();
      check_clean_run(c);
      if (stall_cycles == stalls_before) begin
         report_problem("memory never stalled a command");
      end
      end_test();
   endtask

   task automatic test_data_error;
      tg_config_t c;
      begin_test("data_error");
      ready_random    = 1'b0;
      corrupt_on      = 1'b1;
      corrupt_address = 16'h0207;
      c = make_config(16'h0200, 16'd16, 8'h81);
      start_run(c);
      wait_done();
      corrupt_on = 1'b0;
      check_flag("pass", 1'b0, last_status.pass);
      check_flag("timeout", 1'b0, last_status.timeout);
      check_count("fail_count", 16'd1, last_status.fail_count);
      check_address("first_fail_address", 16'h0207, last_status.first_fail_address);
      end_test();
   endtask

   task automatic test_timeout;
      tg_config_t c;
      begin_test("timeout");
      drop_reads = 1'b1;
      c = make_config(16'h0400, 16'd8, 8'h11);
      start_run(c);
      wait_done();
      drop_reads = 1'b0;
      check_flag("timeout", 1'b1, last_status.timeout);
      check_flag("pass", 1'b0, last_status.pass);
      end_test();
   endtask

   // Follows the timeout run directly, with a new base and seed
   task automatic test_restart;
      tg_config_t c;
      begin_test("restart");
      ready_random = 1'b1;
      c = make_config(16'h8000, 16'd24, 8'he7);
      start_run(c);
      wait_done();
      check_clean_run(c);
      end_test();
   endtask

   initial begin
      reset_n = 1'b0;
      start   = 1'b0;
      cfg     = '0;
      repeat (16) @(posedge clk);
      reset_n <= 1'b1;
      repeat (4) @(posedge clk);
      test_reset_state();
      test_basic_pass();
      test_back_pressure();
      test_data_error();
      test_timeout();
      test_restart();
      $display("tests run %0d, tests failed %0d, failed checks %0d",
               tests_run, tests_failed, error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: amm_tg.f
+incdir+verilog
verilog/amm_tg_pkg.sv
verilog/amm_tg_cmd_bridge.sv
verilog/amm_tg_counters.sv
verilog/amm_tg_ctrl_fsm.sv
verilog/amm_tg_read_checker.sv
verilog/amm_tg_top.sv
tests/amm_tg_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the traffic generator testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module amm_tg_tb \
   -f amm_tg.f -o amm_tg_sim

./obj_dir/amm_tg_sim 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
   echo "simulation reported failures, see sim.log"
   exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
   echo "simulation ended without a result line, see sim.log"
   exit 1
fi
echo "simulation passed"
